// File: source/lcd_pkg.sv
package lcd_pkg;

	// one transfer on the LCD bus, same bit order as {rs, rw, data}
	typedef struct packed {
		logic       rs;	// 0 command, 1 character data
		logic       rw;	// always 0, reads not supported
		logic [7:0] data;
	} lcd_word_t;

	// display settings applied by the init sequence
	typedef struct packed {
		logic display_lines;	// N bit of function set
		logic character_font;	// F bit of function set
		logic display_on;
		logic cursor_on;
		logic blink;
		logic increment;	// I/D bit of entry mode
		logic shift;	// S bit of entry mode
	} lcd_mode_t;

	// physical pins of the HD44780 parallel bus
	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	// 2 x 16 display geometry
	localparam int line_length = 16;

	// DDRAM base address of each line, index is the line number
	localparam logic [1:0][7:0] line_base = {8'h40, 8'h00};

	// set DDRAM address command, address goes in the low 7 bits
	localparam logic [7:0] cmd_set_address = 8'h80;

endpackage

// File: source/lcd_text_writer.sv
`timescale 1ns/100ps
module lcd_text_writer (
	input  logic               clk,
	input  logic               reset,
	input  logic               char_strobe,
	input  logic [7:0]         char_code,
	input  logic               home_strobe,
	input  logic               full,
	output logic               ready,
	output logic               push,
	output lcd_pkg::lcd_word_t push_word
);
	import lcd_pkg::*;

	localparam int col_bits = $clog2(line_length + 1);
	localparam logic [col_bits-1:0] col_wrap = col_bits'(line_length);

	logic                started;	// low only while in reset
	logic                line;	// cursor line, 0 or 1
	logic [col_bits-1:0] col;	// next column to write, 0..line_length
	logic                home_pending;	// address word owed before next char
	logic                addr_valid;	// held address word not yet pushed
	logic                char_valid;	// held character word not yet pushed
	lcd_word_t           addr_word;
	lcd_word_t           char_word;
	logic                wrap;
	logic                next_line;
	logic                accept_home;
	logic                accept_char;

	// line is full, the next character goes to the other line
	assign wrap      = (col == col_wrap);
	assign next_line = wrap ? ~line : line;

	// home has priority over a character in the same cycle
	assign accept_home = ready & home_strobe;
	assign accept_char = ready & char_strobe & ~home_strobe;

	assign ready     = started & ~addr_valid & ~char_valid;
	assign push      = (addr_valid | char_valid) & ~full;
	assign push_word = addr_valid ? addr_word : char_word;	// address goes out first

	always_ff @(posedge clk) begin
		if (reset) begin
			started      <= 1'b0;
			line         <= 1'b0;
			col          <= '0;
			home_pending <= 1'b0;
			addr_valid   <= 1'b0;
			char_valid   <= 1'b0;
		end else begin
			started <= 1'b1;
			if (accept_home) begin
				line         <= 1'b0;
				col          <= '0;
				home_pending <= 1'b1;
			end else if (accept_char) begin
				addr_valid   <= home_pending | wrap;
				char_valid   <= 1'b1;
				home_pending <= 1'b0;
				line         <= next_line;
				col          <= wrap ? col_bits'(1) : col + 1'b1;
			end else if (push) begin
				if (addr_valid)
					addr_valid <= 1'b0;
				else
					char_valid <= 1'b0;
			end
		end
	end

	// held words, loaded together when a character is taken
	always_ff @(posedge clk) begin
		if (accept_char) begin
			addr_word.rs   <= 1'b0;
			addr_word.rw   <= 1'b0;
			addr_word.data <= cmd_set_address | line_base[next_line];
			char_word.rs   <= 1'b1;
			char_word.rw   <= 1'b0;
			char_word.data <= char_code;
		end
	end

endmodule

// File: source/lcd_word_fifo.sv
`timescale 1ns/100ps
module lcd_word_fifo #(
	parameter type item_t = lcd_pkg::lcd_word_t,
	parameter int  depth  = 8
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  item_t push_item,
	input  logic  pop,
	output item_t head_item,
	output logic  empty,
	output logic  full
);

	localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_bits = $clog2(depth + 1);
	localparam logic [ptr_bits-1:0]   last_ptr   = ptr_bits'(depth - 1);
	localparam logic [count_bits-1:0] full_count = count_bits'(depth);

	item_t                 mem [depth];
	logic [ptr_bits-1:0]   rd_ptr;
	logic [ptr_bits-1:0]   wr_ptr;
	logic [count_bits-1:0] count;	// occupancy
	logic                  do_push;
	logic                  do_pop;

	assign empty = (count == '0);
	assign full  = (count == full_count);

	// requests that would overflow or underflow are dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign head_item = mem[rd_ptr];	// show-ahead

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			if (do_push & ~do_pop)
				count <= count + 1'b1;
			else if (do_pop & ~do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_item;
	end

endmodule

// File: source/lcd_controller.sv
`timescale 1ns/100ps
module lcd_controller #(
	parameter int clk_per_us = 25
) (
	input  logic               clk,
	input  logic               reset,
	input  lcd_pkg::lcd_mode_t mode,
	input  logic               empty,
	input  lcd_pkg::lcd_word_t head_word,
	output logic               take,
	output lcd_pkg::lcd_pins_t pins,
	output logic               busy
);
	import lcd_pkg::*;

	localparam int cnt_bits = $clog2(500 * clk_per_us + 1);

	typedef logic [cnt_bits-1:0] count_t;

	// power-up wait
	localparam count_t power_up_end = count_t'(500 * clk_per_us - 1);

	// init schedule, each command has e high for 10 us
	localparam count_t fs_end    = count_t'(10 * clk_per_us);
	localparam count_t dc_start  = count_t'(60 * clk_per_us);
	localparam count_t dc_end    = count_t'(70 * clk_per_us);
	localparam count_t clr_start = count_t'(120 * clk_per_us);
	localparam count_t clr_end   = count_t'(130 * clk_per_us);
	localparam count_t em_start  = count_t'(330 * clk_per_us);
	localparam count_t em_end    = count_t'(340 * clk_per_us);
	localparam count_t init_end  = count_t'(440 * clk_per_us - 1);

	// word transfer, setup 1 us, e high 13 us, 50 us total
	localparam count_t e_rise   = count_t'(clk_per_us);
	localparam count_t e_fall   = count_t'(14 * clk_per_us);
	localparam count_t xfer_end = count_t'(50 * clk_per_us);

	typedef enum logic [1:0] {
		st_power_up,
		st_init,
		st_idle,
		st_transfer
	} state_t;

	state_t    state;
	count_t    cnt;	// cycles since state entry
	lcd_word_t word_q;	// word being sent
	logic [7:0] function_set;
	logic [7:0] display_control;
	logic [7:0] entry_mode;

	// init commands from the requested mode
	assign function_set    = {4'b0011, mode.display_lines, mode.character_font, 2'b00};
	assign display_control = {5'b00001, mode.display_on, mode.cursor_on, mode.blink};
	assign entry_mode      = {6'b000001, mode.increment, mode.shift};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_power_up;
			cnt   <= '0;
		end else begin
			case (state)
				st_power_up: begin
					if (cnt == power_up_end) begin
						state <= st_init;
						cnt   <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
				st_init: begin
					if (cnt == init_end) begin
						state <= st_idle;
						cnt   <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
				st_idle: begin
					cnt <= '0;
					if (!empty)
						state <= st_transfer;
				end
				default: begin	// st_transfer
					if (cnt == xfer_end) begin
						state <= st_idle;
						cnt   <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			word_q <= head_word;
	end

	// pins and handshake decoded from state and counter
	always_comb begin
		pins = '0;
		take = 1'b0;
		busy = 1'b1;
		case (state)
			st_init: begin
				if (cnt < fs_end) begin
					pins.e    = 1'b1;
					pins.data = function_set;
				end else if (cnt >= dc_start && cnt < dc_end) begin
					pins.e    = 1'b1;
					pins.data = display_control;
				end else if (cnt >= clr_start && cnt < clr_end) begin
					pins.e    = 1'b1;
					pins.data = 8'h01;	// clear display
				end else if (cnt >= em_start && cnt < em_end) begin
					pins.e    = 1'b1;
					pins.data = entry_mode;
				end
			end
			st_idle: begin
				take = ~empty;	// pop the head as soon as it shows
				busy = ~empty;
			end
			st_transfer: begin
				pins.rs   = word_q.rs;
				pins.rw   = word_q.rw;
				pins.data = word_q.data;
				pins.e    = (cnt >= e_rise) && (cnt < e_fall);
			end
			default: ;	// power-up, all pins low
		endcase
	end

endmodule

// File: source/lcd_subsystem.sv
`timescale 1ns/100ps
module lcd_subsystem #(
	parameter int clk_per_us = 25,
	parameter int fifo_depth = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               char_strobe,
	input  logic [7:0]         char_code,
	input  logic               home_strobe,
	input  lcd_pkg::lcd_mode_t mode,
	output logic               ready,
	output logic               busy,
	output lcd_pkg::lcd_pins_t pins
);
	import lcd_pkg::*;

	logic      push;
	lcd_word_t push_word;
	logic      full;
	logic      empty;
	lcd_word_t head_word;
	logic      take;

	lcd_text_writer writer (
		.clk        (clk),
		.reset      (reset),
		.char_strobe(char_strobe),
		.char_code  (char_code),
		.home_strobe(home_strobe),
		.full       (full),
		.ready      (ready),
		.push       (push),
		.push_word  (push_word)
	);

	lcd_word_fifo #(
		.item_t(lcd_word_t),
		.depth (fifo_depth)
	) word_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (push),
		.push_item(push_word),
		.pop      (take),
		.head_item(head_word),
		.empty    (empty),
		.full     (full)
	);

	lcd_controller #(
		.clk_per_us(clk_per_us)
	) controller (
		.clk      (clk),
		.reset    (reset),
		.mode     (mode),
		.empty    (empty),
		.head_word(head_word),
		.take     (take),
		.pins     (pins),
		.busy     (busy)
	);

endmodule

// File: bench/lcd_subsystem_tb.sv
`timescale 1ns/100ps
module lcd_subsystem_tb;
	import lcd_pkg::*;

	localparam int clk_per_us  = 1;
	localparam int fifo_depth  = 4;
	localparam int num_entries = 58;

	typedef enum logic [1:0] {
		kind_char,
		kind_home,
		kind_both	// both strobes high so home must win
	} kind_t;

	typedef struct packed {
		kind_t      kind;
		logic [7:0] code;
	} entry_t;

	logic       clk = 1'b0;
	logic       reset;
	logic       char_strobe;
	logic [7:0] char_code;
	logic       home_strobe;
	lcd_mode_t  mode;
	logic       ready;
	logic       busy;
	lcd_pins_t  pins;

	entry_t    stimulus [num_entries];
	lcd_word_t expected_q [$];	// init commands then writer words
	lcd_pins_t last_pins = '0;
	int        e_cycles = 0;	// samples with e high in current pulse
	int        xfer_count = 0;
	int        addr_words = 0;
	int        errors = 0;
	int        checks = 0;
	int        cycles = 0;
	int        limit = 0;
	int        wait_busy;
	integer    seed;

	lcd_subsystem #(
		.clk_per_us(clk_per_us),
		.fifo_depth(fifo_depth)
	) uut (
		.clk        (clk),
		.reset      (reset),
		.char_strobe(char_strobe),
		.char_code  (char_code),
		.home_strobe(home_strobe),
		.mode       (mode),
		.ready      (ready),
		.busy       (busy),
		.pins       (pins)
	);

	always #2 clk = ~clk;

	function automatic lcd_word_t make_word(input logic rs, input logic [7:0] data);
		lcd_word_t w;
		w.rs   = rs;
		w.rw   = 1'b0;	// writes only
		w.data = data;
		return w;
	endfunction

	task automatic check_word(input string name, input lcd_word_t expected,
			input lcd_word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %b actual %b", name, expected, actual);
		end
	endtask

	// printable random codes with a few home requests
	task automatic fill_stimulus();
		for (int i = 0; i < num_entries; i++) begin
			stimulus[i].kind = kind_char;
			stimulus[i].code = 8'h20 + 8'($unsigned($random(seed)) % 95);
		end
		stimulus[34].kind = kind_home;	// after a wrap back to line 0
		stimulus[53].kind = kind_home;
		stimulus[54].kind = kind_both;
	endtask

	// expected bus words from the HD44780 instruction set and cursor rules
	task automatic build_expected();
		int         line;
		int         col;
		logic       home_pending;
		logic [7:0] cmd;
		line = 0;
		col = 0;
		home_pending = 1'b0;
		cmd = 8'h30 | (8'(mode.display_lines) << 3) | (8'(mode.character_font) << 2);
		expected_q.push_back(make_word(1'b0, cmd));	// function set for an 8-bit bus
		cmd = 8'h08 | (8'(mode.display_on) << 2) | (8'(mode.cursor_on) << 1) | 8'(mode.blink);
		expected_q.push_back(make_word(1'b0, cmd));	// display control
		expected_q.push_back(make_word(1'b0, 8'h01));	// clear
		cmd = 8'h04 | (8'(mode.increment) << 1) | 8'(mode.shift);
		expected_q.push_back(make_word(1'b0, cmd));	// entry mode
		foreach (stimulus[i]) begin
			if (stimulus[i].kind != kind_char) begin
				line = 0;
				col = 0;
				home_pending = 1'b1;
			end else begin
				if (col == line_length) begin
					line = 1 - line;	// line 1 wraps to line 0
					col = 0;
					expected_q.push_back(make_word(1'b0, cmd_set_address | line_base[line]));
					addr_words++;
				end else if (home_pending) begin
					expected_q.push_back(make_word(1'b0, cmd_set_address | line_base[line]));
					addr_words++;
				end
				home_pending = 1'b0;
				expected_q.push_back(make_word(1'b1, stimulus[i].code));
				col++;
			end
		end
	endtask

	task automatic apply_entry(input int index, input entry_t entry);
		while (!ready)
			@(negedge clk);
		home_strobe = (entry.kind != kind_char);
		char_strobe = (entry.kind != kind_home);
		char_code   = entry.code;
		@(negedge clk);
		home_strobe = 1'b0;
		char_strobe = 1'b0;
		// a taken character is held for at least one cycle, home only moves the cursor
		check_level($sformatf("ready after entry %0d", index), entry.kind != kind_char, ready);
	endtask

	// transfer ends where e was high and is now low
	always @(negedge clk) begin
		last_pins <= pins;
		if (last_pins.e && !pins.e) begin
			if (xfer_count < expected_q.size())
				check_word($sformatf("transfer %0d", xfer_count), expected_q[xfer_count],
					lcd_word_t'({last_pins.rs, last_pins.rw, last_pins.data}));
			else begin
				errors++;
				$display("transfer %0d appeared on the pins beyond the %0d expected words",
					xfer_count, expected_q.size());
			end
			check_count($sformatf("e high cycles of transfer %0d", xfer_count),
				(xfer_count < 4) ? 10 * clk_per_us : 13 * clk_per_us, e_cycles);
			xfer_count <= xfer_count + 1;
			e_cycles   <= 0;
		end else if (pins.e)
			e_cycles <= e_cycles + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout, the run did not complete within %0d cycles", limit);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		seed        = 57106;
		reset       = 1'b1;
		char_strobe = 1'b0;
		home_strobe = 1'b0;
		char_code   = 8'h00;
		mode        = '{display_lines: 1'b1, character_font: 1'b0, display_on: 1'b1,
			cursor_on: 1'b1, blink: 1'b0, increment: 1'b1, shift: 1'b0};
		fill_stimulus();
		build_expected();
		limit = (940 + 60 * (num_entries + addr_words)) * clk_per_us + 200;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// FIFO is still empty here so busy has to drop once init is over
		while (xfer_count < 4)
			@(negedge clk);
		wait_busy = 0;
		while (busy && wait_busy < 100 * clk_per_us + 10) begin
			@(negedge clk);
			wait_busy++;
		end
		if (busy) begin
			errors++;
			$display("busy stayed high after the initialization sequence");
		end

		foreach (stimulus[i])
			apply_entry(i, stimulus[i]);

		while (xfer_count < expected_q.size())
			@(negedge clk);
		repeat (60 * clk_per_us) @(negedge clk);	// room for any extra transfer
		check_count("transfer count", expected_q.size(), xfer_count);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: filelist.f
source/lcd_pkg.sv
source/lcd_text_writer.sv
source/lcd_word_fifo.sv
source/lcd_controller.sv
source/lcd_subsystem.sv
bench/lcd_subsystem_tb.sv
